// File: Makefile
# Verilator build and run of the gfx mapper testbench

VERILATOR ?= verilator
TOP       ?= tb_gfx_mapper
FILELIST  ?= gfx_mapper_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: gfx_addr_gen.sv
// ****************************************
// stage 1, raw rom address from a tile request
// requests for layers 5..7 are dropped here
// and nowhere else
// ****************************************
`default_nettype none

module gfx_addr_gen (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,   // one cycle strobe
    input  gfx_types_pkg::gfx_req_t  req,
    output logic                     raw_valid,
    output gfx_types_pkg::raw_item_t raw
);

    import gfx_types_pkg::*;
    import gfx_map_pkg::*;

    logic      layer_ok;
    vsub_t     line_sel;
    rom_addr_t raw_addr;

    // only the five real layers get through
    assign layer_ok = (int'(req.layer) < num_layers);

    always_comb begin
        line_sel = req.vsub;
        // scroll1 tiles are 8 lines tall
        if (req.layer == layer_scroll1) begin
            line_sel[3] = 1'b0;
        end
    end

    // a[22:20] layer, a[19:4] code, a[3:0] line
    assign raw_addr = {req.layer, req.code, line_sel};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raw_valid <= 1'b0;
            raw       <= '0;
        end else begin
            raw_valid <= req_valid & layer_ok;
            if (req_valid && layer_ok) begin   // hold last item otherwise
                raw.layer <= req.layer;
                raw.addr  <= raw_addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: gfx_bank_apply.sv
// ****************************************
// stage 3, rewrites address bits 19..16
// output register of the pipeline
// no back-pressure, take rom_item on rom_valid
// ****************************************
`default_nettype none

module gfx_bank_apply (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dec_valid,
    input  gfx_types_pkg::mapped_item_t dec,
    input  gfx_types_pkg::nibble_t      dec_offset,
    input  gfx_types_pkg::nibble_t      dec_mask,
    output logic                        rom_valid,   // strobe
    output gfx_types_pkg::mapped_item_t rom_item
);

    import gfx_types_pkg::*;
    import gfx_map_pkg::*;

    nibble_t   bank_field;
    rom_addr_t mapped_addr;

    // mask first then or in the offset
    assign bank_field = (dec.addr[bank_field_lsb +: nibble_w] & dec_mask) | dec_offset;

    always_comb begin
        mapped_addr = dec.addr;   // all other bits pass through
        mapped_addr[bank_field_lsb +: nibble_w] = bank_field;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_valid <= 1'b0;
            rom_item  <= '0;
        end else begin
            rom_valid <= dec_valid;
            if (dec_valid) begin
                rom_item.layer <= dec.layer;
                rom_item.addr  <= mapped_addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: gfx_bank_decode.sv
// ****************************************
// stage 2, bank decode and game table lookup
// game must stay stable while items are in flight
// offset and mask follow the registered bank select
// ****************************************
`default_nettype none

module gfx_bank_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        raw_valid,
    input  gfx_types_pkg::raw_item_t    raw,
    input  gfx_types_pkg::game_id_t     game,
    output logic                        dec_valid,
    output gfx_types_pkg::mapped_item_t dec,          // raw address still
    output gfx_types_pkg::nibble_t      dec_offset,
    output gfx_types_pkg::nibble_t      dec_mask
);

    import gfx_types_pkg::*;
    import gfx_map_pkg::*;

    bank_sel_t next_sel;
    bank_sel_t bank_sel;
    game_cfg_t cfg;
    logic      a16;

    assign a16 = raw.addr[16];   // splits sprite and scroll3 space

    // decode on a[22:20] and a[16]
    always_comb begin
        case (raw.layer)
            layer_sprites: next_sel = a16 ? bank_sel_2 : bank_sel_0;
            layer_scroll1: next_sel = bank_sel_0;
            layer_scroll2: next_sel = bank_sel_0;
            layer_scroll3: next_sel = a16 ? bank_sel_none : bank_sel_1;
            layer_star:    next_sel = bank_sel_none;   // no rom bank
            default:       next_sel = bank_sel_none;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
            bank_sel  <= bank_sel_none;
            dec       <= '0;
        end else begin
            dec_valid <= raw_valid;
            if (raw_valid) begin   // strobe acts as enable
                bank_sel  <= next_sel;
                dec.layer <= raw.layer;
                dec.addr  <= raw.addr;
            end
        end
    end

    assign cfg = game_table[game[2:0]];

    // pick the nibble pair of the selected bank
    always_comb begin
        case (bank_sel)
            bank_sel_0: {dec_offset, dec_mask} = {cfg.offset[3:0], cfg.mask[3:0]};
            bank_sel_1: {dec_offset, dec_mask} = {cfg.offset[7:4], cfg.mask[7:4]};
            bank_sel_2: {dec_offset, dec_mask} = {cfg.offset[11:8], cfg.mask[11:8]};
            bank_sel_3: {dec_offset, dec_mask} = {cfg.offset[15:12], cfg.mask[15:12]};
            default:    {dec_offset, dec_mask} = {4'h0, 4'hf};   // leave field as is
        endcase
    end

endmodule

`default_nettype wire

// File: gfx_map_pkg.sv
// ****************************************
// board memory map, layer codes and game table
// only the low 3 bits of the game id index the table
// bank3 has table entries but is never decoded
// ****************************************
`default_nettype none

package gfx_map_pkg;

    // layer codes as seen on a[22:20]
    localparam gfx_types_pkg::layer_t layer_sprites = 3'd0;
    localparam gfx_types_pkg::layer_t layer_scroll1 = 3'd1;  // 8 line tiles
    localparam gfx_types_pkg::layer_t layer_scroll2 = 3'd2;
    localparam gfx_types_pkg::layer_t layer_scroll3 = 3'd3;
    localparam gfx_types_pkg::layer_t layer_star    = 3'd4;
    localparam int num_layers = 5;   // codes 5..7 are unused

    // one-hot bank select
    typedef logic [3:0] bank_sel_t;
    localparam bank_sel_t bank_sel_none = 4'b0000;
    localparam bank_sel_t bank_sel_0    = 4'b0001;
    localparam bank_sel_t bank_sel_1    = 4'b0010;
    localparam bank_sel_t bank_sel_2    = 4'b0100;
    localparam bank_sel_t bank_sel_3    = 4'b1000;

    // nibble k of each word belongs to bank k
    typedef struct packed {
        logic [15:0] offset;
        logic [15:0] mask;
    } game_cfg_t;

    // lowest bit of the bank field that gets rewritten
    localparam int bank_field_lsb = 16;

    // per game bank setup
    localparam game_cfg_t game_table [8] = '{
        '{offset: 16'h0000, mask: 16'hffff},   // straight through
        '{offset: 16'h0420, mask: 16'h0013},
        '{offset: 16'h0880, mask: 16'h0377},
        '{offset: 16'h0c40, mask: 16'h0337},
        '{offset: 16'h0a84, mask: 16'h0133},
        '{offset: 16'h0e62, mask: 16'h0111},
        '{offset: 16'h0600, mask: 16'h0fff},
        '{offset: 16'h0f08, mask: 16'h0007}    // small boards
    };

endpackage

`default_nettype wire

// File: gfx_mapper_asserts.sv
// ****************************************
// bound checks on the mapper top level
// latency counted in sampling edges, req to rom
// ****************************************
`default_nettype none

module gfx_mapper_asserts (
    input logic                        clk,
    input logic                        rst,
    input logic                        req_valid,
    input gfx_types_pkg::gfx_req_t     req,
    input logic                        rom_valid,
    input gfx_types_pkg::mapped_item_t rom_item
);
    timeunit 1ns;
    timeprecision 100ps;

    import gfx_types_pkg::*;
    import gfx_map_pkg::*;

    logic        req_ok;           // request that survives stage 1
    int unsigned fail_count = 0;   // assertion failures so far

    assign req_ok = req_valid && (int'(req.layer) < num_layers);

    // no output while the board is in reset
    a_quiet_in_reset: assert property (@(posedge clk) rst |-> !rom_valid)
        else begin
            fail_count++;
            $error("rom_valid high during reset");
        end

    // each kept request shows up three edges later
    a_latency_fwd: assert property (@(posedge clk) disable iff (rst)
        req_ok |-> ##3 rom_valid)
        else begin
            fail_count++;
            $error("kept request produced no rom_valid three cycles later");
        end

    // and nothing comes out without a request behind it
    a_latency_back: assert property (@(posedge clk) disable iff (rst)
        rom_valid |-> $past(req_ok, 3))
        else begin
            fail_count++;
            $error("rom_valid without a kept request three cycles before");
        end

    a_layer_range: assert property (@(posedge clk) disable iff (rst)
        rom_valid |-> (int'(rom_item.layer) < num_layers))
        else begin
            fail_count++;
            $error("rom_item carries an unused layer code");
        end

endmodule

bind gfx_mapper_top gfx_mapper_asserts u_mapper_asserts (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .rom_valid (rom_valid),
    .rom_item  (rom_item)
);

`default_nettype wire

// File: gfx_mapper_top.f
gfx_types_pkg.sv
gfx_map_pkg.sv
gfx_addr_gen.sv
gfx_bank_decode.sv
gfx_bank_apply.sv
gfx_mapper_top.sv
tb_clkgen.sv
gfx_mapper_asserts.sv
tb_gfx_mapper.sv

// File: gfx_mapper_top.sv
// ****************************************
// gfx rom address mapper, three register stages
// rom_valid comes three cycles after req_valid
// one requester, no arbitration, no handshake
// ****************************************
`default_nettype none

module gfx_mapper_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid,
    input  gfx_types_pkg::gfx_req_t     req,
    input  gfx_types_pkg::game_id_t     game,       // level, change only when idle
    output logic                        rom_valid,
    output gfx_types_pkg::mapped_item_t rom_item
);

    import gfx_types_pkg::*;

    // stage 1 to 2
    logic         raw_valid;
    raw_item_t    raw;
    // stage 2 to 3
    logic         dec_valid;
    mapped_item_t dec;
    nibble_t      dec_offset;
    nibble_t      dec_mask;

    gfx_addr_gen u_addr_gen (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .raw_valid (raw_valid),
        .raw       (raw)
    );

    gfx_bank_decode u_bank_decode (
        .clk        (clk),
        .rst        (rst),
        .raw_valid  (raw_valid),
        .raw        (raw),
        .game       (game),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .dec_offset (dec_offset),
        .dec_mask   (dec_mask)
    );

    gfx_bank_apply u_bank_apply (
        .clk        (clk),
        .rst        (rst),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .dec_offset (dec_offset),
        .dec_mask   (dec_mask),
        .rom_valid  (rom_valid),
        .rom_item   (rom_item)
    );

endmodule

`default_nettype wire

// File: gfx_types_pkg.sv
// ****************************************
// data shapes shared by the mapper stages
// the layer is carried next to the address and
// always equals address bits 22 to 20
// ****************************************
`default_nettype none

package gfx_types_pkg;

    // field widths
    localparam int layer_w    = 3;
    localparam int code_w     = 16;
    localparam int vsub_w     = 4;
    localparam int rom_addr_w = 23;   // word address into gfx rom
    localparam int game_w     = 7;
    localparam int nibble_w   = 4;

    typedef logic [layer_w-1:0]    layer_t;     // a[22:20]
    typedef logic [code_w-1:0]     tile_code_t;
    typedef logic [vsub_w-1:0]     vsub_t;      // line inside the tile
    typedef logic [rom_addr_w-1:0] rom_addr_t;
    typedef logic [game_w-1:0]     game_id_t;
    typedef logic [nibble_w-1:0]   nibble_t;    // bank offset or mask

    // request from the layer side
    typedef struct packed {
        layer_t     layer;
        tile_code_t code;
        vsub_t      vsub;
    } gfx_req_t;

    // stage 1 output, address before banking
    typedef struct packed {
        layer_t    layer;
        rom_addr_t addr;
    } raw_item_t;

    // stage 2 and 3 output
    // stage 2 still holds the raw address here
    typedef struct packed {
        layer_t    layer;
        rom_addr_t addr;
    } mapped_item_t;

endpackage

`default_nettype wire

// File: tb_clkgen.sv
// ****************************************
// testbench clock and reset, 40 ns period
// rst high from time zero for reset_cycles edges
// ****************************************
`default_nettype none

module tb_clkgen #(
    parameter int half_period  = 20,   // ns
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2 rst = 1'b0;   // release off the edge
    end

endmodule

`default_nettype wire

// File: tb_gfx_mapper.sv
// ****************************************
// testbench for the gfx rom address mapper
// inputs change 2 ns after the rising edge
// outputs are sampled on the falling edge
// ****************************************
`default_nettype none

module tb_gfx_mapper;
    timeunit 1ns;
    timeprecision 100ps;

    import gfx_types_pkg::*;
    import gfx_map_pkg::*;

    localparam int drive_delay = 2;    // ns after posedge
    localparam int drain_limit = 50;   // cycles
    localparam int reset_limit = 40;   // cycles
    localparam int latency     = 3;    // drive cycle to output cycle

    logic         clk;
    logic         rst;
    logic         req_valid;
    gfx_req_t     req;
    game_id_t     game;
    logic         rom_valid;
    mapped_item_t rom_item;

    integer       seed = 69478;
    int           cycle = 0;
    mapped_item_t exp_item_q[$];   // expected items, in order
    int           exp_cycle_q[$];  // cycle each one must appear in
    mapped_item_t exp_item;
    int           exp_cycle;

    tb_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    gfx_mapper_top u_gfx_mapper_top (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .game      (game),
        .rom_valid (rom_valid),
        .rom_item  (rom_item)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // expected output for one request under one game
    function automatic mapped_item_t expected_map(input gfx_req_t r, input game_id_t g);
        rom_addr_t    a;
        int           bank;
        game_cfg_t    cfg;
        nibble_t      offs;
        nibble_t      msk;
        mapped_item_t m;
        a = {r.layer, r.code, r.vsub};
        if (r.layer == layer_scroll1) begin
            a[3] = 1'b0;   // 8 line tiles
        end
        bank = -1;   // no bank
        if (r.layer == layer_sprites) begin
            bank = a[16] ? 2 : 0;
        end else if (r.layer == layer_scroll1 || r.layer == layer_scroll2) begin
            bank = 0;
        end else if (r.layer == layer_scroll3 && !a[16]) begin
            bank = 1;
        end
        cfg = game_table[g[2:0]];
        if (bank < 0) begin
            offs = 4'h0;
            msk  = 4'hf;
        end else begin
            offs = cfg.offset[bank*4 +: 4];
            msk  = cfg.mask[bank*4 +: 4];
        end
        a[19:16] = (a[19:16] & msk) | offs;
        m.layer = r.layer;
        m.addr  = a;
        return m;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error %0t ns: %s got %h expected %h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idle_cycle();
        logic [31:0] rnd;
        rnd = rand32();
        @(posedge clk);
        #drive_delay;
        req_valid = 1'b0;
        req       = rnd[22:0];   // junk, must be ignored
    endtask

    task automatic drive_req(input layer_t layer, input tile_code_t code, input vsub_t vsub);
        gfx_req_t r;
        r.layer = layer;
        r.code  = code;
        r.vsub  = vsub;
        @(posedge clk);
        #drive_delay;
        req_valid = 1'b1;
        req       = r;
        if (int'(layer) < num_layers) begin   // layers 5..7 vanish
            exp_item_q.push_back(expected_map(r, game));
            exp_cycle_q.push_back(cycle + latency);
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > reset_limit) begin
                $display("Verification failed");
                $fatal(1, "reset never released");
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        idle_cycle();
        while (exp_item_q.size() != 0) begin
            idle_cycle();
            n++;
            if (n > drain_limit) begin
                $display("Verification failed");
                $fatal(1, "expected outputs never came out of the pipeline");
            end
        end
    endtask

    // game is a level, only touched with an empty pipeline
    task automatic set_game(input game_id_t g);
        wait_drain();
        game = g;
    endtask

    // every layer with a16 clear and set
    task automatic sweep(input game_id_t g);
        logic [31:0] rnd;
        tile_code_t  code;
        set_game(g);
        for (int l = 0; l < num_layers; l++) begin
            for (int b = 0; b < 2; b++) begin
                rnd      = rand32();
                code     = rnd[15:0];
                code[12] = b[0];   // lands on a16
                drive_req(l[2:0], code, rnd[19:16]);
            end
        end
    endtask

    task automatic short_tiles();
        logic [31:0] rnd;
        for (int l = 0; l < num_layers; l++) begin
            for (int v = 8; v < 16; v++) begin
                rnd = rand32();
                drive_req(l[2:0], rnd[15:0], v[3:0]);
            end
        end
    endtask

    // unused layers wedged between kept requests
    task automatic dropped_mix();
        logic [31:0] rnd;
        for (int i = 0; i < 30; i++) begin
            rnd = rand32();
            drive_req(3'(rnd[7:0] % 5), rnd[23:8], rnd[27:24]);
            drive_req(3'(5 + rnd[29:28] % 3), rnd[15:0], rnd[3:0]);
            if (rnd[30]) begin
                drive_req(3'd7, rnd[31:16], rnd[7:4]);
            end
        end
    endtask

    task automatic random_burst(input int count, input bit gaps);
        logic [31:0] rnd;
        int          n;
        rnd = rand32();
        set_game(rnd[6:0]);
        for (int i = 0; i < count; i++) begin
            rnd = rand32();
            if (gaps) begin
                n = int'(rnd[25:24]);
                repeat (n) idle_cycle();
            end
            drive_req(rnd[2:0], rnd[18:3], rnd[22:19]);   // any layer code
        end
    endtask

    // compare process, outputs stable at the falling edge
    always @(negedge clk) begin
        if (!rst && rom_valid) begin
            if (exp_item_q.size() == 0) begin
                $display("Verification failed");
                $fatal(1, "rom_valid with no request waiting for it");
            end else begin
                exp_item  = exp_item_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                check_value(32'(rom_item), 32'(exp_item), "rom item");
                check_value(32'(cycle), 32'(exp_cycle), "output cycle");
            end
        end
    end

    // bound checker failures end the run as well
    always @(negedge clk) begin
        if (u_gfx_mapper_top.u_mapper_asserts.fail_count != 0) begin
            $display("Verification failed");
            $fatal(1, "an assertion on the mapper top level failed");
        end
    end

    initial begin
        logic [31:0] rnd;
        req_valid = 1'b0;
        req       = '0;
        game      = '0;
        wait_reset();
        repeat (20) begin   // quiet after reset
            idle_cycle();
            check_value(32'(rom_valid), 32'd0, "rom_valid with no requests");
        end
        sweep(7'd0);
        for (int g = 0; g < 8; g++) begin
            rnd = rand32();
            sweep({rnd[3:0], g[2:0]});   // upper id bits must not matter
        end
        short_tiles();
        dropped_mix();
        random_burst(500, 1'b0);   // full rate
        random_burst(500, 1'b1);
        wait_drain();
        repeat (5) idle_cycle();
        if (u_gfx_mapper_top.u_mapper_asserts.fail_count != 0) begin
            $display("Verification failed");
            $fatal(1, "an assertion on the mapper top level failed");
        end else if (exp_item_q.size() != 0 || exp_cycle_q.size() != 0) begin
            $display("Verification failed");
            $fatal(1, "expected outputs left over at the end");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
